// File: hdl/l3_cfg_pkg.sv
// Geometry of the direct-mapped L3 cache and its split word address
// Stages import this for widths, line count and the number of L2 ports
package l3_cfg_pkg;

  // Address and data sizes
  localparam int addr_width = 16;    // Word address
  localparam int data_width = 32;    // One word per line

  // Direct-mapped split of the address
  localparam int index_width = 4;
  localparam int tag_width   = addr_width - index_width;
  localparam int num_lines   = 1 << index_width;  // 16 lines

  // L2 requesters sharing the cache, port 0 has top priority
  localparam int num_ports     = 4;
  localparam int port_id_width = $clog2(num_ports);

  // Word address as seen by the lookup
  // Tag sits in the upper bits so the struct equals the flat address
  typedef struct packed {
    logic [tag_width-1:0]   tag;
    logic [index_width-1:0] index;
  } l3_addr_t;

endpackage

// File: hdl/l3_bus_pkg.sv
// Transaction formats passed between the L3 stages and main memory
// Request from an L2 port, internal job and completion, memory request
package l3_bus_pkg;

  // Strobed request from one L2 requester
  typedef struct packed {
    logic                              write;  // 1 = store, 0 = load
    l3_cfg_pkg::l3_addr_t              addr;
    logic [l3_cfg_pkg::data_width-1:0] wdata;
  } l2_req_t;

  // Request after selection, tagged with its owner
  typedef struct packed {
    logic [l3_cfg_pkg::port_id_width-1:0] port;
    logic                                 write;
    l3_cfg_pkg::l3_addr_t                 addr;
    logic [l3_cfg_pkg::data_width-1:0]    wdata;
  } l3_job_t;

  // Completion routed back to the owning port
  typedef struct packed {
    logic [l3_cfg_pkg::port_id_width-1:0] port;
    logic [l3_cfg_pkg::data_width-1:0]    rdata;  // Line contents after the access
  } l3_done_t;

  // Word-wide main memory access, eviction write or line fill read
  typedef struct packed {
    logic                              write;
    logic [l3_cfg_pkg::addr_width-1:0] addr;
    logic [l3_cfg_pkg::data_width-1:0] wdata;  // Victim data on a write
  } mem_req_t;

endpackage

// File: hdl/l3_request_select.sv
// Request selection for the L3 cache
// Each port strobe is held in a pending slot, then one job at a time is
// issued to the line controller, lowest port number first
module l3_request_select (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic [l3_cfg_pkg::num_ports-1:0]       req_valid,
  input  l3_bus_pkg::l2_req_t [l3_cfg_pkg::num_ports-1:0] req,
  input  logic                                   cpl_valid,
  output logic                                   job_valid,
  output l3_bus_pkg::l3_job_t                    job
);
  import l3_cfg_pkg::*;
  import l3_bus_pkg::*;

  logic [num_ports-1:0]     pending;         // One waiting request per port
  l2_req_t                  held [num_ports];
  logic                     busy;            // A job is in the line controller
  logic [num_ports-1:0]     first;           // Lowest pending port, one-hot
  logic [num_ports-1:0]     grant;
  logic [port_id_width-1:0] sel;

  // Isolate the lowest set bit for fixed priority
  assign first = pending & (~pending + 1'b1);
  assign job_valid = (|pending) && !busy;
  assign grant = first & {num_ports{job_valid}};

  always_comb begin
    sel = '0;
    for (int p = 0; p < num_ports; p++) begin
      if (first[p]) sel = port_id_width'(p);
    end
  end

  always_comb begin
    job.port  = sel;
    job.write = held[sel].write;
    job.addr  = held[sel].addr;
    job.wdata = held[sel].wdata;
  end

  // Request payload, captured with its strobe
  always_ff @(posedge clk) begin
    for (int p = 0; p < num_ports; p++) begin
      if (req_valid[p]) held[p] <= req[p];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending <= '0;
      busy    <= 1'b0;
    end else begin
      pending <= (pending & ~grant) | req_valid;  // Issued port drops out
      if (job_valid) begin
        busy <= 1'b1;
      end else if (cpl_valid) begin
        busy <= 1'b0;  // Line controller finished the job
      end
    end
  end

endmodule

// File: hdl/l3_line_ctrl.sv
// Line storage and control FSM of the direct-mapped write-back L3 cache
// Takes one job at a time, looks it up, evicts a dirty victim and fills
// read misses from main memory, then reports a completion
module l3_line_ctrl (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              job_valid,
  input  l3_bus_pkg::l3_job_t               job,
  input  logic                              mem_ready,
  input  logic [l3_cfg_pkg::data_width-1:0] mem_rdata,
  output logic                              mem_req_valid,
  output l3_bus_pkg::mem_req_t              mem_req,
  output logic                              cpl_valid,
  output l3_bus_pkg::l3_done_t              cpl,
  output logic                              hit,
  output logic                              miss
);
  import l3_cfg_pkg::*;
  import l3_bus_pkg::*;

  typedef enum logic [1:0] {
    idle,
    lookup,      // Tag compare on the stored job
    evict_wait,  // Dirty victim being written to memory
    fill_wait    // Line read from memory in flight
  } state_t;

  state_t state, next_state;

  // Line arrays
  logic [tag_width-1:0]  tag_mem  [num_lines];
  logic [data_width-1:0] data_mem [num_lines];
  logic [num_lines-1:0]  valid_bits;
  logic [num_lines-1:0]  dirty_bits;

  l3_job_t                job_q;
  logic                   replay;   // Lookup repeated after a memory access
  logic [index_width-1:0] idx;
  logic                   line_hit;
  logic                   victim_dirty;
  l3_addr_t               victim_addr;
  logic                   install;  // Store write data into the line
  logic                   fill;     // Store memory data into the line
  logic                   evicted;  // Victim now safe in memory

  assign idx          = job_q.addr.index;
  assign line_hit     = valid_bits[idx] && (tag_mem[idx] == job_q.addr.tag);
  assign victim_dirty = valid_bits[idx] && dirty_bits[idx];
  assign victim_addr  = '{tag: tag_mem[idx], index: idx};

  // Completion carries the line as it stands after the access
  assign cpl.port  = job_q.port;
  assign cpl.rdata = job_q.write ? job_q.wdata : data_mem[idx];

  always_comb begin
    next_state    = state;
    hit           = 1'b0;
    miss          = 1'b0;
    cpl_valid     = 1'b0;
    mem_req_valid = 1'b0;
    mem_req.write = 1'b0;
    mem_req.addr  = job_q.addr;
    mem_req.wdata = data_mem[idx];
    install       = 1'b0;
    fill          = 1'b0;
    evicted       = 1'b0;
    case (state)
      idle: begin
        if (job_valid) next_state = lookup;
      end
      lookup: begin
        // Strobes only on the first pass of a job
        hit  = line_hit && !replay;
        miss = !line_hit && !replay;
        if (line_hit) begin
          install    = job_q.write;
          cpl_valid  = 1'b1;
          next_state = idle;
        end else if (victim_dirty) begin
          mem_req_valid = 1'b1;
          mem_req.write = 1'b1;
          mem_req.addr  = victim_addr;  // Rebuilt from stored tag
          next_state    = evict_wait;
        end else if (job_q.write) begin
          // Single-word line, nothing to read first
          install    = 1'b1;
          cpl_valid  = 1'b1;
          next_state = idle;
        end else begin
          mem_req_valid = 1'b1;
          next_state    = fill_wait;
        end
      end
      evict_wait: begin
        if (mem_ready) begin
          evicted    = 1'b1;
          next_state = lookup;
        end
      end
      fill_wait: begin
        if (mem_ready) begin
          fill       = 1'b1;
          next_state = lookup;  // Completes as a hit on the new line
        end
      end
      default: next_state = idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= idle;
      replay     <= 1'b0;
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      state <= next_state;
      if (next_state == lookup) replay <= (state != idle);
      if (install) begin
        valid_bits[idx] <= 1'b1;
        dirty_bits[idx] <= 1'b1;
      end else if (fill) begin
        valid_bits[idx] <= 1'b1;
        dirty_bits[idx] <= 1'b0;  // Matches memory
      end else if (evicted) begin
        dirty_bits[idx] <= 1'b0;
      end
    end
  end

  // Job payload and line contents
  always_ff @(posedge clk) begin
    if (state == idle && job_valid) job_q <= job;
    if (install) begin
      tag_mem[idx]  <= job_q.addr.tag;
      data_mem[idx] <= job_q.wdata;
    end else if (fill) begin
      tag_mem[idx]  <= job_q.addr.tag;
      data_mem[idx] <= mem_rdata;
    end
  end

endmodule

// File: hdl/l3_response_route.sv
// Result stage of the L3 cache
// Turns each completion into a registered done strobe on its port and
// keeps that port's read data until its next completion
module l3_response_route (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    cpl_valid,
  input  l3_bus_pkg::l3_done_t                    cpl,
  output logic [l3_cfg_pkg::num_ports-1:0]        done,
  output logic [l3_cfg_pkg::num_ports-1:0][l3_cfg_pkg::data_width-1:0] rdata
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      done  <= '0;
      rdata <= '0;
    end else begin
      done <= '0;  // One-cycle strobe
      if (cpl_valid) begin
        done[cpl.port]  <= 1'b1;
        rdata[cpl.port] <= cpl.rdata;  // Other ports keep their last word
      end
    end
  end

endmodule

// File: hdl/l3_cache.sv
// Top of the shared L3 cache for four L2 requesters
// Request selection feeds the line controller, whose completions are
// routed back to the requesting port, main memory hangs off the middle
module l3_cache (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [l3_cfg_pkg::num_ports-1:0]        req_valid,
  input  l3_bus_pkg::l2_req_t [l3_cfg_pkg::num_ports-1:0] req,
  input  logic                                    mem_ready,
  input  logic [l3_cfg_pkg::data_width-1:0]       mem_rdata,
  output logic                                    mem_req_valid,
  output l3_bus_pkg::mem_req_t                    mem_req,
  output logic [l3_cfg_pkg::num_ports-1:0]        done,
  output logic [l3_cfg_pkg::num_ports-1:0][l3_cfg_pkg::data_width-1:0] rdata,
  output logic                                    hit,
  output logic                                    miss
);
  import l3_bus_pkg::*;

  logic     job_valid;
  l3_job_t  job;
  logic     cpl_valid;
  l3_done_t cpl;

  l3_request_select u_select (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .cpl_valid (cpl_valid),  // Frees the selector for the next job
    .job_valid (job_valid),
    .job       (job)
  );

  l3_line_ctrl u_line (
    .clk           (clk),
    .reset         (reset),
    .job_valid     (job_valid),
    .job           (job),
    .mem_ready     (mem_ready),
    .mem_rdata     (mem_rdata),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .cpl_valid     (cpl_valid),
    .cpl           (cpl),
    .hit           (hit),
    .miss          (miss)
  );

  l3_response_route u_route (
    .clk       (clk),
    .reset     (reset),
    .cpl_valid (cpl_valid),
    .cpl       (cpl),
    .done      (done),
    .rdata     (rdata)
  );

endmodule

// File: sim/l3_tests.svh
// Directed tests for the L3 cache and the shadow memory they check against
// Included inside the testbench module, uses its signals, log and counters
`ifndef L3_TESTS_SVH
`define L3_TESTS_SVH

  logic [data_width-1:0]   shadow [mem_words];  // Expected memory image
  l2_req_t [num_ports-1:0] req_next;
  int                      start_cycle;         // Cycle of the last request strobe
  int                      got_count;
  int                      got_port [num_ports];
  logic [data_width-1:0]   got_data [num_ports];
  int                      got_cycle [num_ports];
  int                      hits0;
  int                      misses0;
  int                      mem0;

  // Power-up memory image
  function automatic logic [data_width-1:0] fill_word(input logic [addr_width-1:0] addr);
    return 32'(addr) * 32'd3 + 32'h1000;
  endfunction

  task automatic init_shadow();
    for (int a = 0; a < mem_words; a++) begin
      shadow[a] = fill_word(addr_width'(a));
    end
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("ERR %s %s: expected %h, actual %h", test, what, exp, act);
    value_errors++;
  endtask

  // Writes go into the shadow in issue order
  task automatic set_req(input int p, input logic write, input logic [addr_width-1:0] addr,
                         input logic [data_width-1:0] wdata);
    req_next[p].write = write;
    req_next[p].addr  = addr;
    req_next[p].wdata = wdata;
    if (write) shadow[addr] = wdata;
  endtask

  task automatic issue(input logic [num_ports-1:0] mask);
    @(negedge clk);
    req         = req_next;
    req_valid   = mask;
    start_cycle = cycle;
    @(negedge clk);
    req_valid = '0;  // One-cycle strobe
  endtask

  task automatic collect_done(input string test, input int count);
    int waited;
    got_count = 0;
    waited    = 0;
    while (got_count < count && waited < 100) begin
      @(negedge clk);
      waited++;
      for (int p = 0; p < num_ports; p++) begin
        if (done[p] && got_count < num_ports) begin
          got_port[got_count]  = p;
          got_data[got_count]  = rdata[p];
          got_cycle[got_count] = cycle;
          got_count++;
        end
      end
    end
    if (got_count < count) begin
      $display("%s: only %0d of %0d done strobes arrived", test, got_count, count);
      strobe_errors++;
    end
  endtask

  task automatic take_snapshot();
    hits0   = hit_count;
    misses0 = miss_count;
    mem0    = mem_log.size();
  endtask

  task automatic check_traffic(input string test, input int hits, input int misses,
                               input int mems);
    if (hit_count - hits0 != hits) report_mismatch(test, "hit pulses", hits, hit_count - hits0);
    if (miss_count - misses0 != misses)
      report_mismatch(test, "miss pulses", misses, miss_count - misses0);
    if (mem_log.size() - mem0 != mems)
      report_mismatch(test, "memory requests", mems, mem_log.size() - mem0);
  endtask

  task automatic check_mem(input string test, input int idx, input logic write,
                           input logic [addr_width-1:0] addr, input logic [data_width-1:0] wdata);
    if (idx >= mem_log.size()) begin
      $display("%s: memory request %0d never appeared", test, idx - mem0);
      strobe_errors++;
    end else begin
      if (mem_log[idx].write !== write)
        report_mismatch(test, "memory write flag", 32'(write), 32'(mem_log[idx].write));
      if (mem_log[idx].addr !== addr)
        report_mismatch(test, "memory address", 32'(addr), 32'(mem_log[idx].addr));
      if (write && mem_log[idx].wdata !== wdata)
        report_mismatch(test, "memory write data", wdata, mem_log[idx].wdata);
    end
  endtask

  task automatic check_data(input string test, input int idx, input logic [data_width-1:0] exp);
    if (idx < got_count && got_data[idx] !== exp)
      report_mismatch(test, "rdata", exp, got_data[idx]);
  endtask

  task automatic cold_read_miss();
    take_snapshot();
    set_req(0, 1'b0, 16'h0123, '0);
    issue(4'b0001);
    collect_done("cold_read_miss", 1);
    check_traffic("cold_read_miss", 0, 1, 1);
    check_mem("cold_read_miss", mem0, 1'b0, 16'h0123, '0);
    check_data("cold_read_miss", 0, shadow[16'h0123]);
  endtask

  task automatic read_hit();
    take_snapshot();
    set_req(1, 1'b0, 16'h0123, '0);
    issue(4'b0010);
    collect_done("read_hit", 1);
    check_traffic("read_hit", 1, 0, 0);
    if (got_count == 1 && got_port[0] != 1)
      report_mismatch("read_hit", "done port", 1, got_port[0]);
    if (got_count == 1 && got_cycle[0] - start_cycle != 3)  // Fixed hit latency
      report_mismatch("read_hit", "done latency", 3, got_cycle[0] - start_cycle);
    check_data("read_hit", 0, shadow[16'h0123]);
  endtask

  task automatic write_then_read();
    take_snapshot();
    set_req(2, 1'b1, 16'h0123, 32'hcafe_0001);
    issue(4'b0100);
    collect_done("write_then_read", 1);
    check_data("write_then_read", 0, 32'hcafe_0001);  // Write done returns the new line
    set_req(3, 1'b0, 16'h0123, '0);
    issue(4'b1000);
    collect_done("write_then_read", 1);
    check_traffic("write_then_read", 2, 0, 0);
    check_data("write_then_read", 0, 32'hcafe_0001);
  endtask

  // Same index 5, tags 0x024 and 0x038
  task automatic dirty_eviction();
    take_snapshot();
    set_req(0, 1'b1, 16'h0245, 32'h5a5a_1234);
    issue(4'b0001);
    collect_done("dirty_eviction", 1);
    check_traffic("dirty_eviction", 0, 1, 0);  // Write miss installs without memory
    take_snapshot();
    set_req(1, 1'b0, 16'h0385, '0);
    issue(4'b0010);
    collect_done("dirty_eviction", 1);
    check_traffic("dirty_eviction", 0, 1, 2);
    check_mem("dirty_eviction", mem0, 1'b1, 16'h0245, 32'h5a5a_1234);
    check_mem("dirty_eviction", mem0 + 1, 1'b0, 16'h0385, '0);
    check_data("dirty_eviction", 0, shadow[16'h0385]);
    take_snapshot();
    set_req(2, 1'b0, 16'h0245, '0);
    issue(4'b0100);
    collect_done("dirty_eviction", 1);
    check_traffic("dirty_eviction", 0, 1, 1);
    check_mem("dirty_eviction", mem0, 1'b0, 16'h0245, '0);
    check_data("dirty_eviction", 0, 32'h5a5a_1234);
  endtask

  task automatic four_ports();
    logic [data_width-1:0] expect_data [num_ports];
    for (int p = 0; p < num_ports; p++) begin
      set_req(p, 1'b0, 16'h0010 + addr_width'(p * 'h11), '0);
      expect_data[p] = shadow[16'h0010 + addr_width'(p * 'h11)];
    end
    issue(4'b1111);
    collect_done("four_ports", 4);
    for (int i = 0; i < got_count; i++) begin
      if (got_port[i] != i) report_mismatch("four_ports", "done order", i, got_port[i]);
      check_data("four_ports", i, expect_data[i]);
    end
  endtask

  // Batches of strobes on random ports, served in port order
  task automatic random_ops();
    int                    ops;
    int                    n;
    logic [num_ports-1:0]  mask;
    logic [addr_width-1:0] a;
    logic                  w;
    int                    order [num_ports];
    logic                  is_read [num_ports];
    logic [data_width-1:0] expect_data [num_ports];
    ops = 0;
    while (ops < 200) begin
      mask = num_ports'($urandom % 15 + 1);
      n    = 0;
      for (int p = 0; p < num_ports; p++) begin
        if (mask[p] && ops < 200) begin
          a              = addr_width'($urandom % 64);
          w              = 1'($urandom % 2);
          expect_data[n] = shadow[a];
          set_req(p, w, a, $urandom);
          order[n]   = p;
          is_read[n] = !w;
          n++;
          ops++;
        end else begin
          mask[p] = 1'b0;
        end
      end
      issue(mask);
      collect_done("random_ops", n);
      for (int i = 0; i < got_count; i++) begin
        if (got_port[i] != order[i])
          report_mismatch("random_ops", "done port", order[i], got_port[i]);
        else if (is_read[i]) check_data("random_ops", i, expect_data[i]);
      end
    end
  endtask

`endif

// File: sim/l3_cache_tb.sv
// Testbench for the shared L3 cache in front of a word-wide main memory model
// Runs the directed tests from the included test file, then prints one closing report
module l3_cache_tb;
  import l3_cfg_pkg::*;
  import l3_bus_pkg::*;

  // 200 random ops at roughly 15 cycles worst case, plus the directed tests
  localparam int cycle_limit = 6000;
  localparam int mem_words   = 1 << addr_width;

  logic                                 clk;
  logic                                 reset;
  logic [num_ports-1:0]                 req_valid;
  l2_req_t [num_ports-1:0]              req;
  logic                                 mem_ready = 1'b0;
  logic [data_width-1:0]                mem_rdata = '0;
  logic                                 mem_req_valid;
  mem_req_t                             mem_req;
  logic [num_ports-1:0]                 done;
  logic [num_ports-1:0][data_width-1:0] rdata;
  logic                                 hit;
  logic                                 miss;

  logic [data_width-1:0] main_mem [mem_words];
  mem_req_t              mem_log [$];  // Every memory request, in order
  mem_req_t              mem_cur;      // Request the memory is serving
  int                    mem_wait = 0;
  int                    hit_count = 0;
  int                    miss_count = 0;
  int                    cycle = 0;
  int                    value_errors = 0;
  int                    strobe_errors = 0;

  `include "l3_tests.svh"

  l3_cache dut (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req           (req),
    .mem_ready     (mem_ready),
    .mem_rdata     (mem_rdata),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .done          (done),
    .rdata         (rdata),
    .hit           (hit),
    .miss          (miss)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("Timeout: run still busy after %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  // Main memory, one request at a time, answered after 1 to 4 cycles
  always @(negedge clk) begin
    mem_ready = 1'b0;
    if (mem_wait > 0) begin
      mem_wait = mem_wait - 1;
      if (mem_wait == 0) begin
        mem_ready = 1'b1;
        mem_rdata = main_mem[mem_cur.addr];
      end
    end
    if (!reset && mem_req_valid) begin
      mem_cur = mem_req;
      mem_log.push_back(mem_req);
      if (mem_req.write) main_mem[mem_req.addr] = mem_req.wdata;  // Eviction lands here
      mem_wait = int'($urandom % 4) + 1;
    end
  end

  // Strobe counters for the lookup outcome
  always @(negedge clk) begin
    if (!reset) begin
      if (hit) hit_count++;
      if (miss) miss_count++;
      if (hit && miss) begin
        $display("Hit and miss were both high in cycle %0d", cycle);
        strobe_errors++;
      end
    end
  end

  initial begin
    void'($urandom(63419));
    reset     = 1'b1;
    req_valid = '0;
    req       = '0;
    for (int a = 0; a < mem_words; a++) begin
      main_mem[a] = fill_word(addr_width'(a));
    end
    init_shadow();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    cold_read_miss();
    read_hit();
    write_then_read();
    dirty_eviction();
    four_ports();
    random_ops();
    repeat (4) @(negedge clk);
    $display("Closing report: %0d value errors, %0d strobe errors", value_errors, strobe_errors);
    if (value_errors + strobe_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: l3_cache.f
+incdir+sim
hdl/l3_cfg_pkg.sv
hdl/l3_bus_pkg.sv
hdl/l3_request_select.sv
hdl/l3_line_ctrl.sv
hdl/l3_response_route.sv
hdl/l3_cache.sv
sim/l3_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the L3 cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f l3_cache.f --top-module l3_cache_tb -o l3_cache_sim
out=$(./obj_dir/l3_cache_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "All tests passed!"; then
  exit 0
fi
exit 1
